// File: filelist.f
verilog/cache_pkg.sv
verilog/line_store.sv
verilog/line_memory.sv
verilog/perf_counters.sv
verilog/mem_router.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tests/cache_checker.sv
tests/tb_cache_top.sv

// File: tests/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
	input logic clk,
	input logic rst,
	input logic read_request,
	input logic write_request,
	input logic read_response,
	input logic write_response
);

	logic outstanding;
	logic outstanding_read; // kind of the request in flight.
	logic seen_request; // set by the first request after reset.
	int failures = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= 1'b0;
			outstanding_read <= 1'b0;
			seen_request <= 1'b0;
		end else if (read_request || write_request) begin
			outstanding <= 1'b1;
			outstanding_read <= read_request;
			seen_request <= 1'b1;
		end else if (read_response || write_response) begin
			outstanding <= 1'b0;
		end
	end

	one_response: assert property (@(posedge clk) disable iff (rst)
		!(read_response && write_response))
	else begin
		$error("read and write response in the same cycle");
		failures++;
	end

	response_matches_request: assert property (@(posedge clk) disable iff (rst)
		(read_response || write_response) |-> (outstanding && outstanding_read == read_response))
	else begin
		$error("response without a matching outstanding request");
		failures++;
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
		(read_response || write_response) |-> seen_request)
	else begin
		$error("response after reset before any request");
		failures++;
	end

endmodule

bind cache_top cache_checker u_checker (.*);

// File: tests/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top import cache_pkg::*; ();

	localparam int sets = 16;
	localparam int mem_lines = 256;
	localparam int mem_latency = 4;
	localparam addr_t iregion_end = 32'h3ff;
	localparam int count_w = 16;
	localparam int num_requests = 742; // sum over the six tests.
	localparam int cycle_limit = num_requests * (mem_latency * 2 + 8) + sets + 200;
	localparam int miss_min = 3 + mem_latency + 2;

	logic clk = 1'b0;
	logic rst;
	addr_t addr;
	word_t wdata;
	strobe_t strobe;
	logic read_request, write_request, counters_clear;
	word_t rdata;
	logic read_response, write_response;
	logic [count_w-1:0] i_accesses, i_misses, d_accesses, d_misses;

	word_t img [mem_lines*line_words]; // model memory with one entry per word.
	logic tag_valid [2][sets]; // cache 0 is the instruction cache.
	int tag_value [2][sets];
	int exp_acc [2];
	int exp_miss [2];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycle_count = 0;

	cache_top #(.sets(sets), .mem_lines(mem_lines), .mem_latency(mem_latency),
		.iregion_end(iregion_end), .count_w(count_w)) dut (.*);

	initial forever #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic int cache_of(addr_t a);
		return (a <= iregion_end) ? 0 : 1;
	endfunction

	function automatic int index_of(addr_t a);
		return (a >> offset_w) % sets;
	endfunction

	function automatic int tag_of(addr_t a);
		return (a >> offset_w) / sets;
	endfunction

	function automatic addr_t rand_addr(addr_t lo, addr_t hi);
		return lo + ($urandom % ((hi - lo) / 4 + 1)) * 4;
	endfunction

	// updates the expected counts, and the tags when a miss allocates.
	function automatic logic model_access(addr_t a, logic allocate);
		int c;
		int idx;
		logic hit;
		c = cache_of(a);
		idx = index_of(a);
		hit = tag_valid[c][idx] && tag_value[c][idx] == tag_of(a);
		exp_acc[c]++;
		if (!hit) begin
			exp_miss[c]++;
			if (allocate) begin
				tag_valid[c][idx] = 1'b1;
				tag_value[c][idx] = tag_of(a);
			end
		end
		return hit;
	endfunction

	task automatic check(string name, logic [63:0] got, logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
		end
	endtask

	task automatic send(input logic is_read, input addr_t a, input word_t wd, input strobe_t sb,
			output int latency, output logic was_read);
		int cycles;
		@(posedge clk);
		#1;
		addr = a;
		wdata = wd;
		strobe = sb;
		read_request = is_read;
		write_request = !is_read;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			read_request = 1'b0;
			write_request = 1'b0;
			cycles++;
		end while (!(read_response || write_response));
		latency = cycles;
		was_read = read_response;
	endtask

	task automatic do_read(addr_t a);
		logic hit;
		int latency;
		logic was_read;
		hit = model_access(a, 1'b1);
		send(1'b1, a, '0, '0, latency, was_read);
		check("read_response", was_read, 1'b1);
		check("rdata", rdata, img[a / 4]);
		if (hit)
			check("hit latency", latency, 3);
		else
			check("miss latency at least minimum", latency >= miss_min, 1'b1);
	endtask

	task automatic do_write(addr_t a, word_t wd, strobe_t sb);
		int latency;
		logic was_read;
		void'(model_access(a, 1'b0)); // no allocation on a write miss.
		for (int b = 0; b < word_w / 8; b++) begin
			if (sb[b])
				img[a / 4][8*b +: 8] = wd[8*b +: 8];
		end
		send(1'b0, a, wd, sb, latency, was_read);
		check("write_response", !was_read, 1'b1);
	endtask

	task automatic compare_counts();
		check("i_accesses", i_accesses, exp_acc[0]);
		check("i_misses", i_misses, exp_miss[0]);
		check("d_accesses", d_accesses, exp_acc[1]);
		check("d_misses", d_misses, exp_miss[1]);
	endtask

	task automatic finish_test(string name, int start);
		compare_counts();
		tests++;
		$display("test %0d %s: %0d failed checks", tests, name, errors - start);
	endtask

	initial begin
		int start;
		int miss0;
		int total;
		addr_t a;
		void'($urandom(32'hdd58_14b5));
		rst = 1'b1;
		addr = '0;
		wdata = '0;
		strobe = '0;
		read_request = 1'b0;
		write_request = 1'b0;
		counters_clear = 1'b0;
		for (int l = 0; l < mem_lines; l++) begin
			for (int w = 0; w < line_words; w++) begin
				img[l*line_words + w] = $urandom;
				dut.u_memory.mem[l][w] = img[l*line_words + w];
			end
		end
		for (int s = 0; s < sets; s++) begin
			tag_valid[0][s] = 1'b0;
			tag_valid[1][s] = 1'b0;
			tag_value[0][s] = 0;
			tag_value[1][s] = 0;
		end
		exp_acc = '{0, 0};
		exp_miss = '{0, 0};
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		while (dut.u_icache.tag_wr_en || dut.u_dcache.tag_wr_en) begin
			@(posedge clk);
			#1;
		end

		start = errors;
		repeat (300) do_read(rand_addr(0, 32'hffc));
		finish_test("read correctness", start);

		start = errors;
		repeat (100) begin // four lines per region, so most reads hit.
			a = (($urandom % 2) ? 32'h400 : 32'h0) + ($urandom % 4) * 16 + ($urandom % 4) * 4;
			do_read(a);
		end
		finish_test("hit latency", start);

		start = errors;
		repeat (200) begin
			a = rand_addr(32'h400, 32'h4fc) + (($urandom % 2) ? 32'h400 : 32'h0);
			if ($urandom % 2)
				do_write(a, $urandom, 1 + $urandom % 15);
			else
				do_read(a);
		end
		finish_test("write merge", start);

		start = errors;
		repeat (60) do_read(rand_addr(iregion_end - 63, iregion_end + 64));
		finish_test("region split", start);

		start = errors;
		@(posedge clk);
		#1 counters_clear = 1'b1;
		@(posedge clk);
		#1 counters_clear = 1'b0;
		exp_acc = '{0, 0};
		exp_miss = '{0, 0};
		compare_counts();
		repeat (40) begin
			a = rand_addr(0, 32'hffc);
			if (a > iregion_end && $urandom % 2)
				do_write(a, $urandom, 4'hf);
			else
				do_read(a);
		end
		finish_test("counter clear", start);

		start = errors;
		for (int r = 0; r < 2; r++) begin
			a = (r ? 32'h400 : 32'h0) + ($urandom % sets) * 16;
			do_read(a + 32'h100); // a third tag leaves both conflict lines cold.
			miss0 = r ? d_misses : i_misses;
			repeat (10) begin
				do_read(a);
				do_read(a + (r ? 32'h400 : 32'h200));
			end
			check(r ? "d_misses" : "i_misses", (r ? d_misses : i_misses) - miss0, 20);
		end
		finish_test("conflict misses", start);

		total = errors + dut.u_checker.failures;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, checks, errors, dut.u_checker.failures);
		if (total == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
	parameter int sets = 16,
	parameter int mem_lines = 256,
	parameter bit writable = 1'b1
) (
	input logic clk,
	input logic rst,
	input logic rd,
	input logic wr,
	input addr_t req_addr,
	input word_t wdata,
	input strobe_t strobe,
	output logic done,
	output word_t rdata,
	output logic access,
	output logic miss,
	output logic mem_rd,
	output logic mem_wr,
	output logic [$clog2(mem_lines)-1:0] line_addr,
	output logic [$clog2(line_words)-1:0] word_sel,
	output word_t mem_wdata,
	output strobe_t mem_strobe,
	input logic mem_ack,
	input line_t mem_rdata,
	output logic [$clog2(sets)-1:0] tag_rd_index,
	output logic tag_wr_en,
	output logic [$clog2(sets)-1:0] tag_wr_index,
	output tag_entry_t tag_wr_data,
	input tag_entry_t tag_rd_data,
	output logic [$clog2(sets)-1:0] data_rd_index,
	output logic data_wr_en,
	output logic [$clog2(sets)-1:0] data_wr_index,
	output line_t data_wr_data,
	input line_t data_rd_data
);

	localparam int index_w = $clog2(sets);
	localparam int line_aw = $clog2(mem_lines);
	localparam int sel_w = $clog2(line_words);
	localparam int tag_bits = line_aw - index_w;

	typedef enum logic [2:0] {clear, idle, lookup, refill, fill, write_mem} state_t;

	state_t state;
	logic [index_w-1:0] clear_idx;
	addr_t addr_q;
	logic write_q;
	word_t wdata_q;
	strobe_t strobe_q;
	line_t line_buf;
	line_t merged;
	logic [tag_w-1:0] addr_tag;
	logic [sel_w-1:0] word_idx;
	logic hit;
	logic start_write;

	assign start_write = writable && wr; // constant low in the instruction cache.

	assign addr_tag = tag_w'(addr_q[offset_w+index_w +: tag_bits]);
	assign word_idx = addr_q[2 +: sel_w];
	assign hit = tag_rd_data.valid && (tag_rd_data.tag == addr_tag);

	// both stores are read with the address the router presents.
	assign tag_rd_index = req_addr[offset_w +: index_w];
	assign data_rd_index = req_addr[offset_w +: index_w];

	assign tag_wr_en = (state == clear) || (state == fill);
	assign tag_wr_index = (state == clear) ? clear_idx : addr_q[offset_w +: index_w];

	always_comb begin
		tag_wr_data.valid = state == fill;
		tag_wr_data.tag = (state == fill) ? addr_tag : '0;
	end

	// strobed bytes of the write land on top of the stored line.
	always_comb begin
		merged = data_rd_data;
		for (int b = 0; b < word_w/8; b++) begin
			if (strobe_q[b])
				merged[word_idx][8*b +: 8] = wdata_q[8*b +: 8];
		end
	end

	assign data_wr_en = (state == fill) || (state == lookup && write_q && hit);
	assign data_wr_index = addr_q[offset_w +: index_w];
	assign data_wr_data = (state == fill) ? line_buf : merged;

	assign access = state == lookup;
	assign miss = (state == lookup) && !hit;

	assign line_addr = addr_q[offset_w +: line_aw];
	assign word_sel = word_idx;
	assign mem_wdata = wdata_q;
	assign mem_strobe = strobe_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= clear;
			clear_idx <= '0;
			write_q <= 1'b0;
			done <= 1'b0;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				clear: begin
					clear_idx <= clear_idx + 1'b1;
					if (clear_idx == index_w'(sets - 1))
						state <= idle;
				end
				idle: begin
					if (rd || start_write) begin
						write_q <= start_write;
						state <= lookup;
					end
				end
				lookup: begin
					if (write_q) begin // writes go through without allocation on a miss.
						mem_wr <= 1'b1;
						state <= write_mem;
					end else if (hit) begin
						done <= 1'b1;
						state <= idle;
					end else begin
						mem_rd <= 1'b1;
						state <= refill;
					end
				end
				refill: begin
					if (mem_ack) begin
						mem_rd <= 1'b0;
						state <= fill;
					end
				end
				fill: begin
					done <= 1'b1;
					state <= idle;
				end
				write_mem: begin
					if (mem_ack) begin
						mem_wr <= 1'b0;
						done <= 1'b1;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && (rd || start_write)) begin
			addr_q <= req_addr;
			wdata_q <= wdata;
			strobe_q <= strobe;
		end
		if (state == lookup && hit)
			rdata <= data_rd_data[word_idx];
		if (state == refill && mem_ack)
			line_buf <= mem_rdata;
		if (state == fill)
			rdata <= line_buf[word_idx];
	end

endmodule

// File: verilog/cache_pkg.sv
package cache_pkg;

	localparam int word_w = 32;
	localparam int line_words = 4;
	localparam int addr_w = 32;
	localparam int offset_w = 4; // byte offset within a line.
	localparam int tag_w = 8;

	typedef logic [word_w-1:0] word_t;
	typedef logic [word_w/8-1:0] strobe_t;
	typedef logic [addr_w-1:0] addr_t;

	// word 0 sits in the low bits of the line.
	typedef word_t [line_words-1:0] line_t;

	// only the low bits of tag are used, the rest stay zero.
	typedef struct packed {
		logic valid;
		logic [tag_w-1:0] tag;
	} tag_entry_t;

endpackage

// File: verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
	parameter int sets = 16,
	parameter int mem_lines = 256,
	parameter int mem_latency = 4,
	parameter addr_t iregion_end = 32'h3ff,
	parameter int count_w = 16
) (
	input logic clk,
	input logic rst,
	input addr_t addr,
	input word_t wdata,
	input strobe_t strobe,
	input logic read_request,
	input logic write_request,
	input logic counters_clear,
	output word_t rdata,
	output logic read_response,
	output logic write_response,
	output logic [count_w-1:0] i_accesses,
	output logic [count_w-1:0] i_misses,
	output logic [count_w-1:0] d_accesses,
	output logic [count_w-1:0] d_misses
);

	localparam int index_w = $clog2(sets);
	localparam int line_aw = $clog2(mem_lines);
	localparam int sel_w = $clog2(line_words);

	addr_t req_addr;
	logic i_rd, d_rd, d_wr, i_done, d_done;
	word_t i_rdata, d_rdata, d_wdata;
	strobe_t d_strobe;

	logic i_access, i_miss, d_access, d_miss;
	logic i_mem_rd, i_mem_ack, d_mem_rd, d_mem_wr, d_mem_ack;
	logic [line_aw-1:0] i_line_addr, d_line_addr;
	logic [sel_w-1:0] d_word_sel;
	word_t d_mem_wdata;
	strobe_t d_mem_strobe;
	line_t mem_rdata; // the shared line bus is taken only by the acknowledged cache.

	logic [index_w-1:0] it_rd_index, it_wr_index, id_rd_index, id_wr_index;
	logic [index_w-1:0] dt_rd_index, dt_wr_index, dd_rd_index, dd_wr_index;
	logic it_wr_en, id_wr_en, dt_wr_en, dd_wr_en;
	tag_entry_t it_wr_data, it_rd_data, dt_wr_data, dt_rd_data;
	line_t id_wr_data, id_rd_data, dd_wr_data, dd_rd_data;

	mem_router #(.iregion_end(iregion_end)) u_router (
		.clk, .rst, .addr, .wdata, .strobe, .read_request, .write_request,
		.i_rd, .d_rd, .d_wr, .req_addr, .d_wdata, .d_strobe,
		.i_done, .i_rdata, .d_done, .d_rdata,
		.rdata, .read_response, .write_response
	);

	cache_ctrl #(.sets(sets), .mem_lines(mem_lines), .writable(1'b0)) u_icache (
		.clk, .rst, .rd(i_rd), .wr(1'b0), .req_addr, .wdata('0), .strobe('0),
		.done(i_done), .rdata(i_rdata), .access(i_access), .miss(i_miss),
		.mem_rd(i_mem_rd), .mem_wr(), .line_addr(i_line_addr), .word_sel(),
		.mem_wdata(), .mem_strobe(), .mem_ack(i_mem_ack), .mem_rdata,
		.tag_rd_index(it_rd_index), .tag_wr_en(it_wr_en), .tag_wr_index(it_wr_index),
		.tag_wr_data(it_wr_data), .tag_rd_data(it_rd_data),
		.data_rd_index(id_rd_index), .data_wr_en(id_wr_en), .data_wr_index(id_wr_index),
		.data_wr_data(id_wr_data), .data_rd_data(id_rd_data)
	);

	cache_ctrl #(.sets(sets), .mem_lines(mem_lines), .writable(1'b1)) u_dcache (
		.clk, .rst, .rd(d_rd), .wr(d_wr), .req_addr, .wdata(d_wdata), .strobe(d_strobe),
		.done(d_done), .rdata(d_rdata), .access(d_access), .miss(d_miss),
		.mem_rd(d_mem_rd), .mem_wr(d_mem_wr), .line_addr(d_line_addr),
		.word_sel(d_word_sel), .mem_wdata(d_mem_wdata), .mem_strobe(d_mem_strobe),
		.mem_ack(d_mem_ack), .mem_rdata,
		.tag_rd_index(dt_rd_index), .tag_wr_en(dt_wr_en), .tag_wr_index(dt_wr_index),
		.tag_wr_data(dt_wr_data), .tag_rd_data(dt_rd_data),
		.data_rd_index(dd_rd_index), .data_wr_en(dd_wr_en), .data_wr_index(dd_wr_index),
		.data_wr_data(dd_wr_data), .data_rd_data(dd_rd_data)
	);

	line_store #(.depth(sets), .entry_t(tag_entry_t)) u_itags (
		.clk, .rd_index(it_rd_index), .wr_en(it_wr_en), .wr_index(it_wr_index),
		.wr_data(it_wr_data), .rd_data(it_rd_data)
	);

	line_store #(.depth(sets), .entry_t(line_t)) u_idata (
		.clk, .rd_index(id_rd_index), .wr_en(id_wr_en), .wr_index(id_wr_index),
		.wr_data(id_wr_data), .rd_data(id_rd_data)
	);

	line_store #(.depth(sets), .entry_t(tag_entry_t)) u_dtags (
		.clk, .rd_index(dt_rd_index), .wr_en(dt_wr_en), .wr_index(dt_wr_index),
		.wr_data(dt_wr_data), .rd_data(dt_rd_data)
	);

	line_store #(.depth(sets), .entry_t(line_t)) u_ddata (
		.clk, .rd_index(dd_rd_index), .wr_en(dd_wr_en), .wr_index(dd_wr_index),
		.wr_data(dd_wr_data), .rd_data(dd_rd_data)
	);

	line_memory #(.mem_lines(mem_lines), .mem_latency(mem_latency)) u_memory (
		.clk, .rst, .i_rd(i_mem_rd), .i_line_addr, .i_ack(i_mem_ack),
		.d_rd(d_mem_rd), .d_wr(d_mem_wr), .d_line_addr, .d_word_sel,
		.d_wdata(d_mem_wdata), .d_strobe(d_mem_strobe), .d_ack(d_mem_ack),
		.rdata(mem_rdata)
	);

	perf_counters #(.count_w(count_w)) u_counters (
		.clk, .rst, .clear(counters_clear),
		.i_access, .i_miss, .d_access, .d_miss,
		.i_accesses, .i_misses, .d_accesses, .d_misses
	);

endmodule

// File: verilog/line_memory.sv
`timescale 1ns/1ps

module line_memory import cache_pkg::*; #(
	parameter int mem_lines = 256,
	parameter int mem_latency = 4
) (
	input logic clk,
	input logic rst,
	input logic i_rd,
	input logic [$clog2(mem_lines)-1:0] i_line_addr,
	output logic i_ack,
	input logic d_rd,
	input logic d_wr,
	input logic [$clog2(mem_lines)-1:0] d_line_addr,
	input logic [$clog2(line_words)-1:0] d_word_sel,
	input word_t d_wdata,
	input strobe_t d_strobe,
	output logic d_ack,
	output line_t rdata
);

	localparam int line_aw = $clog2(mem_lines);
	localparam int cnt_w = $clog2(mem_latency + 1);

	line_t mem [mem_lines];

	logic busy;
	logic owner_d;
	logic [cnt_w-1:0] count;
	logic grant_d;
	logic finish;
	logic write_q;
	logic [line_aw-1:0] addr_q;
	logic [$clog2(line_words)-1:0] sel_q;
	word_t wdata_q;
	strobe_t strobe_q;

	assign grant_d = d_rd || d_wr; // data cache wins a tie.
	assign finish = busy && (count == '0);
	assign d_ack = finish && owner_d;
	assign i_ack = finish && !owner_d;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			owner_d <= 1'b0;
			count <= '0;
		end else if (!busy) begin
			count <= cnt_w'(mem_latency - 1);
			if (grant_d || i_rd) begin
				busy <= 1'b1;
				owner_d <= grant_d;
			end
		end else if (finish) begin
			busy <= 1'b0;
		end else begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			addr_q <= grant_d ? d_line_addr : i_line_addr;
			rdata <= mem[grant_d ? d_line_addr : i_line_addr];
			write_q <= d_wr;
			sel_q <= d_word_sel;
			wdata_q <= d_wdata;
			strobe_q <= d_strobe;
		end
		if (finish && write_q) begin
			for (int b = 0; b < word_w/8; b++) begin
				if (strobe_q[b])
					mem[addr_q][sel_q][8*b +: 8] <= wdata_q[8*b +: 8];
			end
		end
	end

endmodule

// File: verilog/line_store.sv
`timescale 1ns/1ps

module line_store #(
	parameter int depth = 16,
	parameter type entry_t = logic [31:0]
) (
	input logic clk,
	input logic [$clog2(depth)-1:0] rd_index,
	input logic wr_en,
	input logic [$clog2(depth)-1:0] wr_index,
	input entry_t wr_data,
	output entry_t rd_data
);

	entry_t mem [depth];

	// a read in the cycle of a write to the same entry sees the old value.
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_index] <= wr_data;
		rd_data <= mem[rd_index];
	end

endmodule

// File: verilog/mem_router.sv
`timescale 1ns/1ps

module mem_router import cache_pkg::*; #(
	parameter addr_t iregion_end = 32'h3ff
) (
	input logic clk,
	input logic rst,
	input addr_t addr,
	input word_t wdata,
	input strobe_t strobe,
	input logic read_request,
	input logic write_request,
	output logic i_rd,
	output logic d_rd,
	output logic d_wr,
	output addr_t req_addr,
	output word_t d_wdata,
	output strobe_t d_strobe,
	input logic i_done,
	input word_t i_rdata,
	input logic d_done,
	input word_t d_rdata,
	output word_t rdata,
	output logic read_response,
	output logic write_response
);

	logic rd_q;
	logic wr_q;
	logic is_read_q; // kind of the outstanding request.
	logic sel_i_q; // the instruction cache holds it.
	logic pending;
	logic in_iregion;

	assign in_iregion = req_addr <= iregion_end;

	assign i_rd = rd_q && in_iregion;
	assign d_rd = rd_q && !in_iregion;
	assign d_wr = wr_q; // writes never target the instruction region.

	assign rdata = sel_i_q ? i_rdata : d_rdata;
	assign read_response = pending && is_read_q && (sel_i_q ? i_done : d_done);
	assign write_response = pending && !is_read_q && d_done;

	always_ff @(posedge clk) begin
		if (read_request || write_request) begin
			req_addr <= addr;
			d_wdata <= wdata;
			d_strobe <= strobe;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
			is_read_q <= 1'b0;
			sel_i_q <= 1'b0;
			pending <= 1'b0;
		end else begin
			rd_q <= read_request;
			wr_q <= write_request;
			if (read_request || write_request) begin
				pending <= 1'b1;
				is_read_q <= read_request;
			end else if (read_response || write_response) begin
				pending <= 1'b0;
			end
			if (rd_q || wr_q)
				sel_i_q <= i_rd; // remembered for the whole access.
		end
	end

endmodule

// File: verilog/perf_counters.sv
`timescale 1ns/1ps

module perf_counters #(
	parameter int count_w = 16
) (
	input logic clk,
	input logic rst,
	input logic clear,
	input logic i_access,
	input logic i_miss,
	input logic d_access,
	input logic d_miss,
	output logic [count_w-1:0] i_accesses,
	output logic [count_w-1:0] i_misses,
	output logic [count_w-1:0] d_accesses,
	output logic [count_w-1:0] d_misses
);

	logic [3:0] inc;
	logic [count_w-1:0] count [4];

	assign inc = {d_miss, d_access, i_miss, i_access};

	// each counter holds at its maximum instead of wrapping.
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			for (int n = 0; n < 4; n++)
				count[n] <= '0;
		end else begin
			for (int n = 0; n < 4; n++) begin
				if (inc[n] && count[n] != '1)
					count[n] <= count[n] + 1'b1;
			end
		end
	end

	assign i_accesses = count[0];
	assign i_misses = count[1];
	assign d_accesses = count[2];
	assign d_misses = count[3];

endmodule
